// File: design/sck_divider.sv
`timescale 1ns/1ps

module sck_divider #(
  parameter int clk_div = 125
) (
  input  logic clock_100M,
  input  logic reset,
  output logic sck_rise,
  output logic sck_fall
);

  localparam int cnt_w = (clk_div > 1) ? $clog2(clk_div) : 1;

  logic [cnt_w-1:0] cnt;
  logic             phase;
  logic             wrap;

  assign wrap = (cnt == cnt_w'(clk_div - 1));

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      cnt      <= '0;
      phase    <= 1'b0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      if (wrap) begin
        cnt      <= '0;
        phase    <= ~phase;
        sck_rise <= ~phase; // phase going high
        sck_fall <= phase;  // phase going low
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// File: design/sd_cmd_framer.sv
`timescale 1ns/1ps

module sd_cmd_framer (
  input  sd_pkg::sd_cmd_t cmd,
  output logic [47:0]     frame
);

  import sd_pkg::*;

  // everything ahead of the crc field
  localparam int crc_bits = (frame_bytes - 1) * 8;

  logic [crc_bits-1:0] payload;
  logic [6:0]          crc;
  logic                fb;

  // crc7, x^7 + x^3 + 1, msb first over the 40 leading bits
  always_comb begin
    payload = {1'b0, 1'b1, cmd.index, cmd.arg}; // start bit, transmission bit
    crc     = '0;
    fb      = 1'b0;
    for (int i = crc_bits - 1; i >= 0; i--) begin
      fb  = payload[i] ^ crc[6];
      crc = {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    end
    frame = {payload, crc, 1'b1}; // end bit
  end

endmodule

// File: design/sd_cmd_sequencer.sv
`timescale 1ns/1ps

module sd_cmd_sequencer #(
  parameter int n_poll = 8
) (
  input  logic              clock_100M,
  input  logic              reset,
  input  logic              cmd_start,
  input  sd_pkg::sd_cmd_t   cmd,
  input  logic [47:0]       frame,
  input  logic              byte_done,
  input  logic [7:0]        rx_byte,
  output sd_pkg::sd_cmd_t   cmd_held,
  output logic              byte_start,
  output logic [7:0]        tx_byte,
  output logic              cs,
  output logic              busy,
  output logic              resp_valid,
  output sd_pkg::sd_resp_t  resp,
  output sd_pkg::sd_state_e state
);

  import sd_pkg::*;

  localparam int poll_w = (n_poll > 1) ? $clog2(n_poll) : 1;

  logic [47:0]       frame_sh;
  logic [2:0]        byte_cnt;
  logic [poll_w-1:0] poll_cnt;
  sd_resp_t          result;

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      state      <= idle;
      cs         <= 1'b1;
      busy       <= 1'b0;
      resp_valid <= 1'b0;
      byte_start <= 1'b0;
      byte_cnt   <= '0;
      poll_cnt   <= '0;
      cmd_held   <= '0;
      resp       <= '0;
    end else begin
      byte_start <= 1'b0;
      resp_valid <= 1'b0;
      case (state)
        idle: begin
          if (cmd_start) begin
            cmd_held <= cmd;
            busy     <= 1'b1;
            state    <= select;
          end
        end
        select: begin
          cs         <= 1'b0;
          tx_byte    <= frame[47:40];            // token goes out msb first
          frame_sh   <= {frame[39:0], 8'hff};
          byte_start <= 1'b1;
          byte_cnt   <= '0;
          state      <= send;
        end
        send: begin
          if (byte_done) begin
            byte_start <= 1'b1;
            if (byte_cnt == 3'(frame_bytes - 1)) begin
              tx_byte  <= 8'hff;
              poll_cnt <= '0;
              state    <= poll;
            end else begin
              tx_byte  <= frame_sh[47:40];
              frame_sh <= {frame_sh[39:0], 8'hff};
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end
        poll: begin
          if (byte_done) begin
            byte_start <= 1'b1;
            tx_byte    <= 8'hff;
            if (!rx_byte[7]) begin // r1 always starts with a 0
              result <= '{timeout: 1'b0, r1: rx_byte};
              cs     <= 1'b1;
              state  <= trail;
            end else if (poll_cnt == poll_w'(n_poll - 1)) begin
              result <= '{timeout: 1'b1, r1: 8'hff};
              cs     <= 1'b1;
              state  <= trail;
            end else begin
              poll_cnt <= poll_cnt + 1'b1;
            end
          end
        end
        trail: begin
          if (byte_done) begin // eight clocks with cs high
            resp       <= result;
            resp_valid <= 1'b1;
            busy       <= 1'b0;
            state      <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// File: design/sd_debug_display.sv
`timescale 1ns/1ps

module sd_debug_display (
  input  logic              clock_100M,
  input  logic              reset,
  input  logic              resp_valid,
  input  sd_pkg::sd_state_e state,
  input  sd_pkg::sd_cmd_t   cmd_held,
  input  sd_pkg::sd_resp_t  resp,
  input  logic [4:0]        sw,
  output logic [9:0]        led
);

  logic [7:0] done_cnt;
  logic [7:0] timeout_cnt;

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      done_cnt    <= '0;
      timeout_cnt <= '0;
    end else if (resp_valid) begin
      done_cnt <= done_cnt + 1'b1; // wraps at 256
      if (resp.timeout) begin
        timeout_cnt <= timeout_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (sw)
      5'd0:    led = {7'b0, state};
      5'd1:    led = {1'b0, resp.timeout, resp.r1};
      5'd2:    led = {4'b0, cmd_held.index};
      5'd3:    led = {2'b0, done_cnt};
      5'd4:    led = {2'b0, timeout_cnt};
      default: led = '0;
    endcase
  end

endmodule

// File: design/sd_pkg.sv
package sd_pkg;

  // one host command as issued on cmd_start
  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
  } sd_cmd_t;

  // outcome of one command, r1 reads 8'hff on timeout
  typedef struct packed {
    logic       timeout;
    logic [7:0] r1;
  } sd_resp_t;

  typedef enum logic [2:0] {
    idle,
    select,
    send,
    poll,
    trail
  } sd_state_e;

  // r1 status bits
  localparam logic [7:0] r1_idle        = 8'h01; // bit 0, card in idle state
  localparam logic [7:0] r1_illegal_cmd = 8'h04; // bit 2
  localparam logic [7:0] r1_crc_error   = 8'h08; // bit 3

  // start/tx bits, index, arg, crc7 and end bit
  localparam int frame_bytes = 6;

endpackage

// File: design/sd_spi_top.sv
`timescale 1ns/1ps

module sd_spi_top #(
  parameter int clk_div = 125,
  parameter int n_poll  = 8
) (
  input  logic             clock_100M,
  input  logic             reset,
  input  logic             cmd_start,
  input  sd_pkg::sd_cmd_t  cmd,
  output logic             busy,
  output logic             resp_valid,
  output sd_pkg::sd_resp_t resp,
  input  logic             miso,
  output logic             cs,
  output logic             sck,
  output logic             mosi,
  input  logic [4:0]       sw,
  output logic [9:0]       led
);

  import sd_pkg::*;

  logic        sck_rise;
  logic        sck_fall;
  logic [47:0] frame;
  logic        byte_start;
  logic [7:0]  tx_byte;
  logic        byte_done;
  logic [7:0]  rx_byte;
  sd_cmd_t     cmd_held;
  sd_state_e   state;

  sck_divider #(
    .clk_div(clk_div)
  ) u_sck_divider (
    .clock_100M(clock_100M),
    .reset     (reset),
    .sck_rise  (sck_rise),
    .sck_fall  (sck_fall)
  );

  sd_cmd_framer u_framer (
    .cmd  (cmd_held),
    .frame(frame)
  );

  spi_byte_engine u_byte_engine (
    .clock_100M(clock_100M),
    .reset     (reset),
    .sck_rise  (sck_rise),
    .sck_fall  (sck_fall),
    .byte_start(byte_start),
    .tx_byte   (tx_byte),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .byte_done (byte_done),
    .rx_byte   (rx_byte)
  );

  sd_cmd_sequencer #(
    .n_poll(n_poll)
  ) u_sequencer (
    .clock_100M(clock_100M),
    .reset     (reset),
    .cmd_start (cmd_start),
    .cmd       (cmd),
    .frame     (frame),
    .byte_done (byte_done),
    .rx_byte   (rx_byte),
    .cmd_held  (cmd_held),
    .byte_start(byte_start),
    .tx_byte   (tx_byte),
    .cs        (cs),
    .busy      (busy),
    .resp_valid(resp_valid),
    .resp      (resp),
    .state     (state)
  );

  sd_debug_display u_display (
    .clock_100M(clock_100M),
    .reset     (reset),
    .resp_valid(resp_valid),
    .state     (state),
    .cmd_held  (cmd_held),
    .resp      (resp),
    .sw        (sw),
    .led       (led)
  );

endmodule

// File: design/spi_byte_engine.sv
`timescale 1ns/1ps

module spi_byte_engine (
  input  logic       clock_100M,
  input  logic       reset,
  input  logic       sck_rise,
  input  logic       sck_fall,
  input  logic       byte_start,
  input  logic [7:0] tx_byte,
  input  logic       miso,
  output logic       sck,
  output logic       mosi,
  output logic       byte_done,
  output logic [7:0] rx_byte
);

  logic       active;
  logic [2:0] bit_cnt;
  logic [7:0] tx_sh;
  logic [7:0] rx_sh;
  logic       load;
  logic       rise_edge;
  logic       fall_edge;
  logic       last_fall;

  assign load      = !active && byte_start;
  assign rise_edge = active && sck_rise && !sck;
  assign fall_edge = active && sck_fall && sck; // falls before the first rise are skipped
  assign last_fall = fall_edge && (bit_cnt == 3'd7);

  assign mosi = active ? tx_sh[7] : 1'b1; // idle high between bytes

  always_ff @(posedge clock_100M) begin
    if (reset) begin
      active    <= 1'b0;
      sck       <= 1'b0;
      bit_cnt   <= '0;
      byte_done <= 1'b0;
    end else begin
      byte_done <= last_fall;
      if (load) begin
        active  <= 1'b1;
        bit_cnt <= '0;
      end else if (rise_edge) begin
        sck <= 1'b1;
      end else if (fall_edge) begin
        sck     <= 1'b0;
        bit_cnt <= bit_cnt + 1'b1;
        if (last_fall) begin
          active <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock_100M) begin
    if (load) begin
      tx_sh <= tx_byte;
    end else if (fall_edge) begin
      tx_sh <= {tx_sh[6:0], 1'b1}; // next bit onto mosi
    end
    if (rise_edge) begin
      rx_sh <= {rx_sh[6:0], miso};
    end
    if (last_fall) begin
      rx_byte <= rx_sh;
    end
  end

endmodule

// File: src.f
design/sd_pkg.sv
design/sck_divider.sv
design/sd_cmd_framer.sv
design/spi_byte_engine.sv
design/sd_cmd_sequencer.sv
design/sd_debug_display.sv
design/sd_spi_top.sv
tb/sd_card_model.sv
tb/tb_sd_spi_top.sv

// File: tb/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
  input  logic        cs,
  input  logic        sck,
  input  logic        mosi,
  output logic        miso,
  input  logic        silent,
  input  logic [2:0]  fill,
  output logic [47:0] token
);

  import sd_pkg::*;

  logic [7:0] out_q[$];
  logic [7:0] out_sh;
  int         bit_cnt;

  // crc7 with polynomial 0x09, msb first
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [6:0] c;
    logic       msb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      msb = c[6] ^ bits[i];
      c   = {c[5:0], 1'b0};
      if (msb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  function automatic logic [7:0] answer(input logic [47:0] t);
    if (t[47] || !t[46] || !t[0] || (crc7(t[47:8]) != t[7:1])) begin
      return r1_crc_error; // bad framing bits count as a crc error too
    end
    case (t[45:40])
      6'd8, 6'd13, 6'd16, 6'd17, 6'd24, 6'd41, 6'd55, 6'd58, 6'd59: return 8'h00;
      6'd0:    return r1_idle;
      default: return r1_illegal_cmd;
    endcase
  endfunction

  initial begin
    miso    = 1'b1;
    out_sh  = 8'hff;
    bit_cnt = 0;
    token   = '0;
  end

  always @(negedge cs) begin
    bit_cnt = 0;
    out_q.delete();
    out_sh = 8'hff;
    miso   = 1'b1;
  end

  // mosi is stable on the rising edge in mode 0
  always @(posedge sck) begin
    if (!cs) begin
      if (bit_cnt < 48) begin
        token = {token[46:0], mosi};
      end
      bit_cnt++;
      if (bit_cnt == 48 && !silent) begin
        repeat (fill) out_q.push_back(8'hff);
        out_q.push_back(answer(token));
      end
    end
  end

  always @(negedge sck) begin
    if (!cs) begin
      if (bit_cnt % 8 == 0) begin // byte boundary
        if (out_q.size() > 0) begin
          out_sh = out_q.pop_front();
        end else begin
          out_sh = 8'hff;
        end
      end else begin
        out_sh = {out_sh[6:0], 1'b1};
      end
      miso = out_sh[7];
    end
  end

endmodule

// File: tb/tb_sd_spi_top.sv
`timescale 1ns/1ps

module tb_sd_spi_top;

  import sd_pkg::*;

  localparam int clk_div     = 4;
  localparam int n_poll      = 8;
  localparam int n_cmds      = 27; // cmd0, 20 legal, 4 illegal, busy strobe, silent
  localparam int cycle_limit = 2000 * clk_div * n_cmds;

  localparam logic [59:0] legal_list   = {6'd0, 6'd8, 6'd13, 6'd16, 6'd17,
                                          6'd24, 6'd41, 6'd55, 6'd58, 6'd59};
  localparam logic [23:0] illegal_list = {6'd1, 6'd12, 6'd33, 6'd63};

  logic        clock_100M;
  logic        reset;
  logic        cmd_start;
  sd_cmd_t     cmd;
  logic        busy;
  logic        resp_valid;
  sd_resp_t    resp;
  logic        miso;
  logic        cs;
  logic        sck;
  logic        mosi;
  logic [4:0]  sw;
  logic [9:0]  led;
  logic        silent;
  logic [2:0]  fill;
  logic [47:0] token;

  logic [31:0] lfsr;
  int          cycle_count = 0;
  int          cmd_count;
  int          timeout_count;
  sd_cmd_t     last_cmd;
  sd_resp_t    last_resp;

  sd_spi_top #(
    .clk_div(clk_div),
    .n_poll (n_poll)
  ) u_dut (
    .clock_100M(clock_100M),
    .reset     (reset),
    .cmd_start (cmd_start),
    .cmd       (cmd),
    .busy      (busy),
    .resp_valid(resp_valid),
    .resp      (resp),
    .miso      (miso),
    .cs        (cs),
    .sck       (sck),
    .mosi      (mosi),
    .sw        (sw),
    .led       (led)
  );

  sd_card_model u_card (
    .cs    (cs),
    .sck   (sck),
    .mosi  (mosi),
    .miso  (miso),
    .silent(silent),
    .fill  (fill),
    .token (token)
  );

  initial begin
    clock_100M = 1'b0;
    forever #5 clock_100M = ~clock_100M;
  end

  always @(posedge clock_100M) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      stop_on_failure($sformatf("run went past %0d cycles without finishing", cycle_limit));
    end
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic compare_resp(input sd_resp_t got, input sd_resp_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("[ERROR] resp: got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic compare_cmd(input sd_cmd_t got, input sd_cmd_t exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("[ERROR] token cmd: got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic compare_led(input logic [9:0] got, input logic [9:0] exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("[ERROR] led: got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic sd_cmd_t make_cmd(input logic [5:0] index, input logic [31:0] arg);
    sd_cmd_t c;
    c.index = index;
    c.arg   = arg;
    return c;
  endfunction

  function automatic sd_resp_t make_resp(input logic to, input logic [7:0] r1);
    sd_resp_t r;
    r.timeout = to;
    r.r1      = r1;
    return r;
  endfunction

  task automatic select_view(input logic [4:0] view);
    sw = view;
    @(posedge clock_100M);
    #1;
  endtask

  task automatic run_command(input sd_cmd_t c, input logic [2:0] f, input logic quiet,
                             input logic poke, input sd_resp_t exp);
    sd_cmd_t seen;
    fill      = f;
    silent    = quiet;
    cmd       = c;
    cmd_start = 1'b1;
    @(posedge clock_100M);
    #1;
    cmd_start = 1'b0;
    compare_bit("busy", busy, 1'b1);
    if (sw == 5'd0) begin
      compare_led(led, {7'b0, select}); // first state after the accept
    end
    if (poke) begin
      cmd       = make_cmd(c.index ^ 6'h2a, ~c.arg); // should be ignored
      cmd_start = 1'b1;
      @(posedge clock_100M);
      #1;
      cmd_start = 1'b0;
    end
    while (!resp_valid) begin
      @(posedge clock_100M);
      #1;
    end
    seen = token[45:8];
    compare_bit("cs", cs, 1'b1);
    compare_bit("busy", busy, 1'b0);
    compare_resp(resp, exp);
    compare_cmd(seen, c);
    cmd_count++;
    if (exp.timeout) begin
      timeout_count++;
    end
    last_cmd  = c;
    last_resp = exp;
  endtask

  task automatic check_reset_state();
    compare_bit("cs", cs, 1'b1);
    compare_bit("sck", sck, 1'b0);
    compare_bit("mosi", mosi, 1'b1);
    compare_bit("busy", busy, 1'b0);
    compare_bit("resp_valid", resp_valid, 1'b0);
    compare_led(led, 10'h000);
  endtask

  task automatic test_cmd0();
    run_command(make_cmd(6'd0, 32'h0), 3'd0, 1'b0, 1'b0, make_resp(1'b0, r1_idle));
  endtask

  task automatic test_legal_commands();
    logic [5:0]  idx;
    logic [31:0] arg;
    logic [2:0]  f;
    for (int i = 0; i < 20; i++) begin
      idx = legal_list[(rand_bits(4) % 10) * 6 +: 6];
      arg = rand_bits(32);
      f   = 3'(rand_bits(3));
      run_command(make_cmd(idx, arg), f, 1'b0, 1'b0,
                  make_resp(1'b0, (idx == 6'd0) ? r1_idle : 8'h00));
    end
  endtask

  task automatic test_illegal_commands();
    logic [31:0] arg;
    logic [2:0]  f;
    for (int i = 0; i < 4; i++) begin
      arg = rand_bits(32);
      f   = 3'(rand_bits(3));
      run_command(make_cmd(illegal_list[i*6 +: 6], arg), f, 1'b0, 1'b0,
                  make_resp(1'b0, r1_illegal_cmd));
    end
  endtask

  task automatic test_busy_strobe();
    sw = 5'd0; // state view while the command runs
    run_command(make_cmd(6'd24, rand_bits(32)), 3'd2, 1'b0, 1'b1, make_resp(1'b0, 8'h00));
    sw = 5'd3;
  endtask

  task automatic test_silent_card();
    run_command(make_cmd(6'd17, rand_bits(32)), 3'd0, 1'b1, 1'b0, make_resp(1'b1, 8'hff));
  endtask

  task automatic test_display();
    select_view(5'd3);
    compare_led(led, 10'(cmd_count));
    select_view(5'd4);
    compare_led(led, 10'(timeout_count));
    select_view(5'd2);
    compare_led(led, {4'b0, last_cmd.index});
    select_view(5'd1);
    compare_led(led, {1'b0, last_resp.timeout, last_resp.r1});
    select_view(5'd0);
    compare_led(led, {7'b0, idle});
    select_view(5'd7);
    compare_led(led, 10'h000);
  endtask

  initial begin
    reset         = 1'b1;
    cmd_start     = 1'b0;
    cmd           = '0;
    sw            = 5'd3;
    silent        = 1'b0;
    fill          = 3'd0;
    lfsr          = 32'hc87c_0c02;
    cmd_count     = 0;
    timeout_count = 0;
    last_cmd      = '0;
    last_resp     = '0;
    repeat (4) @(posedge clock_100M);
    #1;
    reset = 1'b0;
    check_reset_state();
    test_cmd0();
    test_legal_commands();
    test_illegal_commands();
    test_busy_strobe();
    test_silent_card();
    test_display();
    $display("NO ERRORS");
    $finish;
  end

endmodule
